/* common/memsys_pkg.sv */
// bus widths, opcode and response enums, port request/response and AXI4-Lite channel structs
package memsys_pkg;

  localparam int ADDR_W = 32;           // byte address
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;   // one strobe per byte lane

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // ----------------------------------------
  // requester side
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } data_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;     // slave answered SLVERR
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // ----------------------------------------
  // AXI4-Lite channels, ready travels apart
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_addr_t;                // shared by AW and AR

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic       valid;
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    axil_resp_e        resp;
  } axil_r_t;

endpackage

/* verilog/mem_req_router.sv */
// mem_req_router: round-robin read arbitration, write steering and response routing
`timescale 1ns/1ps

module mem_req_router (
  input  logic                          i_aclk,
  input  logic                          i_reset,
  input  memsys_pkg::fetch_req_t        i_fetch_req,
  output logic                          o_fetch_req_ready,
  input  memsys_pkg::data_req_t         i_data_req,
  output logic                          o_data_req_ready,
  output memsys_pkg::mem_rsp_t          o_fetch_rsp,
  output memsys_pkg::mem_rsp_t          o_data_rsp,
  output logic                          o_rd_valid,
  output logic [memsys_pkg::ADDR_W-1:0] o_rd_addr,
  output logic                          o_rd_src,
  input  logic                          i_rd_ready,
  output logic                          o_wr_valid,
  output logic [memsys_pkg::ADDR_W-1:0] o_wr_addr,
  output logic [memsys_pkg::DATA_W-1:0] o_wr_data,
  output logic [memsys_pkg::STRB_W-1:0] o_wr_strb,
  input  logic                          i_wr_ready,
  input  logic                          i_rd_done,
  input  logic [memsys_pkg::DATA_W-1:0] i_rd_data,
  input  memsys_pkg::axil_resp_e        i_rd_resp,
  input  logic                          i_rd_src,
  input  logic                          i_wr_done,
  input  memsys_pkg::axil_resp_e        i_wr_resp
);

  localparam logic SRC_FETCH = 1'b0;
  localparam logic SRC_DATA  = 1'b1;

  logic fetch_rd;
  logic data_rd;
  logic data_wr;
  logic grant_fetch;
  logic grant_data;
  logic prio_data_q;   // set when load/store wins the next tie

  assign fetch_rd = i_fetch_req.valid;
  assign data_rd  = i_data_req.valid && (i_data_req.op == memsys_pkg::MEM_READ);
  assign data_wr  = i_data_req.valid && (i_data_req.op == memsys_pkg::MEM_WRITE);

  // ----------------------------------------
  // read arbitration
  assign grant_fetch = fetch_rd && (!data_rd || !prio_data_q);
  assign grant_data  = data_rd && !grant_fetch;

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      prio_data_q <= 1'b0;                   // fetch first after reset
    end else if (o_rd_valid && i_rd_ready) begin
      prio_data_q <= grant_fetch;            // loser goes first next time
    end
  end

  assign o_rd_valid = fetch_rd || data_rd;
  assign o_rd_addr  = grant_fetch ? i_fetch_req.addr : i_data_req.addr;
  assign o_rd_src   = grant_fetch ? SRC_FETCH : SRC_DATA;

  // writes bypass arbitration
  assign o_wr_valid = data_wr;
  assign o_wr_addr  = i_data_req.addr;
  assign o_wr_data  = i_data_req.wdata;
  assign o_wr_strb  = i_data_req.wstrb;

  assign o_fetch_req_ready = grant_fetch && i_rd_ready;
  assign o_data_req_ready  = data_wr ? i_wr_ready : (grant_data && i_rd_ready);

  // ----------------------------------------
  // completions back to the issuing port
  always_comb begin
    o_fetch_rsp.valid = i_rd_done && (i_rd_src == SRC_FETCH);
    o_fetch_rsp.err   = (i_rd_resp == memsys_pkg::RESP_SLVERR);
    o_fetch_rsp.rdata = i_rd_data;

    o_data_rsp.valid  = (i_rd_done && (i_rd_src == SRC_DATA)) || i_wr_done;
    o_data_rsp.err    = i_wr_done ? (i_wr_resp == memsys_pkg::RESP_SLVERR)
                                  : (i_rd_resp == memsys_pkg::RESP_SLVERR);
    o_data_rsp.rdata  = i_wr_done ? '0 : i_rd_data;   // no data on write ack
  end

endmodule

/* axil_master/axil_master_bridge.sv */
// axil_master_bridge: AXI4-Lite master with separate read and write channel FSMs
`timescale 1ns/1ps

module axil_master_bridge (
  input  logic                          i_aclk,
  input  logic                          i_reset,
  input  logic                          i_rd_valid,
  input  logic [memsys_pkg::ADDR_W-1:0] i_rd_addr,
  input  logic                          i_rd_src,
  output logic                          o_rd_ready,
  input  logic                          i_wr_valid,
  input  logic [memsys_pkg::ADDR_W-1:0] i_wr_addr,
  input  logic [memsys_pkg::DATA_W-1:0] i_wr_data,
  input  logic [memsys_pkg::STRB_W-1:0] i_wr_strb,
  output logic                          o_wr_ready,
  output logic                          o_rd_done,
  output logic [memsys_pkg::DATA_W-1:0] o_rd_data,
  output memsys_pkg::axil_resp_e        o_rd_resp,
  output logic                          o_rd_src,
  output logic                          o_wr_done,
  output memsys_pkg::axil_resp_e        o_wr_resp,
  output memsys_pkg::axil_addr_t        o_aw,
  input  logic                          i_awready,
  output memsys_pkg::axil_w_t           o_w,
  input  logic                          i_wready,
  input  memsys_pkg::axil_b_t           i_b,
  output logic                          o_bready,
  output memsys_pkg::axil_addr_t        o_ar,
  input  logic                          i_arready,
  input  memsys_pkg::axil_r_t           i_r,
  output logic                          o_rready
);

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

  localparam logic [2:0] PROT_USER_DATA = 3'b000;   // unprivileged, secure, data

  rd_state_e                     rd_state;
  rd_state_e                     rd_next;
  wr_state_e                     wr_state;
  wr_state_e                     wr_next;
  logic                          rd_ready_q;
  logic                          wr_ready_q;
  logic                          rd_accept;
  logic                          wr_accept;
  logic                          ar_fire;
  logic                          r_fire;
  logic                          aw_fire;
  logic                          w_fire;
  logic                          b_fire;
  logic [memsys_pkg::ADDR_W-1:0] rd_addr_q;
  logic                          rd_src_q;
  logic [memsys_pkg::ADDR_W-1:0] wr_addr_q;
  logic [memsys_pkg::DATA_W-1:0] wr_data_q;
  logic [memsys_pkg::STRB_W-1:0] wr_strb_q;
  logic                          rd_done_q;
  logic [memsys_pkg::DATA_W-1:0] rd_data_q;
  memsys_pkg::axil_resp_e        rd_resp_q;
  logic                          wr_done_q;
  memsys_pkg::axil_resp_e        wr_resp_q;

  assign rd_accept = i_rd_valid && rd_ready_q;
  assign wr_accept = i_wr_valid && wr_ready_q;
  assign ar_fire   = (rd_state == RD_ADDR) && i_arready;
  assign r_fire    = (rd_state == RD_DATA) && i_r.valid;
  assign aw_fire   = (wr_state == WR_ADDR) && i_awready;
  assign w_fire    = (wr_state == WR_DATA) && i_wready;
  assign b_fire    = (wr_state == WR_RESP) && i_b.valid;

  // ----------------------------------------
  // read channel
  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      RD_IDLE: if (rd_accept) rd_next = RD_ADDR;
      RD_ADDR: if (ar_fire)   rd_next = RD_DATA;
      RD_DATA: if (r_fire)    rd_next = RD_IDLE;
      default:                rd_next = RD_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      rd_state   <= RD_IDLE;
      rd_ready_q <= 1'b0;
      rd_done_q  <= 1'b0;
    end else begin
      rd_state   <= rd_next;
      rd_ready_q <= (rd_next == RD_IDLE);   // tracks idle from the cycle after reset
      rd_done_q  <= r_fire;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (rd_accept) begin
      rd_addr_q <= i_rd_addr;
      rd_src_q  <= i_rd_src;
    end
    if (r_fire) begin
      rd_data_q <= i_r.data;
      rd_resp_q <= i_r.resp;
    end
  end

  // ----------------------------------------
  // write channel
  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      WR_IDLE: if (wr_accept) wr_next = WR_ADDR;
      WR_ADDR: if (aw_fire)   wr_next = WR_DATA;
      WR_DATA: if (w_fire)    wr_next = WR_RESP;
      WR_RESP: if (b_fire)    wr_next = WR_IDLE;
      default:                wr_next = WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      wr_state   <= WR_IDLE;
      wr_ready_q <= 1'b0;
      wr_done_q  <= 1'b0;
    end else begin
      wr_state   <= wr_next;
      wr_ready_q <= (wr_next == WR_IDLE);
      wr_done_q  <= b_fire;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_accept) begin
      wr_addr_q <= i_wr_addr;
      wr_data_q <= i_wr_data;
      wr_strb_q <= i_wr_strb;
    end
    if (b_fire) begin
      wr_resp_q <= i_b.resp;
    end
  end

  // ----------------------------------------
  // AXI side
  always_comb begin
    o_ar.valid = (rd_state == RD_ADDR);
    o_ar.addr  = rd_addr_q;
    o_ar.prot  = PROT_USER_DATA;
    o_aw.valid = (wr_state == WR_ADDR);
    o_aw.addr  = wr_addr_q;
    o_aw.prot  = PROT_USER_DATA;
    o_w.valid  = (wr_state == WR_DATA);
    o_w.data   = wr_data_q;
    o_w.strb   = wr_strb_q;
  end

  assign o_rready = (rd_state == RD_DATA);
  assign o_bready = (wr_state == WR_RESP);

  // router side
  assign o_rd_ready = rd_ready_q;
  assign o_wr_ready = wr_ready_q;
  assign o_rd_done  = rd_done_q;
  assign o_rd_data  = rd_data_q;
  assign o_rd_resp  = rd_resp_q;
  assign o_rd_src   = rd_src_q;    // held until the next accept
  assign o_wr_done  = wr_done_q;
  assign o_wr_resp  = wr_resp_q;

endmodule

/* verilog/axil_sram_slave.sv */
// axil_sram_slave: AXI4-Lite word memory with byte strobes and SLVERR past the end
`timescale 1ns/1ps

module axil_sram_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic                   i_aclk,
  input  logic                   i_reset,
  input  memsys_pkg::axil_addr_t i_aw,
  output logic                   o_awready,
  input  memsys_pkg::axil_w_t    i_w,
  output logic                   o_wready,
  output memsys_pkg::axil_b_t    o_b,
  input  logic                   i_bready,
  input  memsys_pkg::axil_addr_t i_ar,
  output logic                   o_arready,
  output memsys_pkg::axil_r_t    o_r,
  input  logic                   i_rready
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [memsys_pkg::DATA_W-1:0] mem [MEM_WORDS];

  logic                          r_valid_q;
  logic [memsys_pkg::DATA_W-1:0] r_data_q;
  memsys_pkg::axil_resp_e        r_resp_q;
  logic                          aw_got_q;
  logic                          w_got_q;
  logic [memsys_pkg::ADDR_W-1:0] aw_addr_q;
  logic [memsys_pkg::DATA_W-1:0] w_data_q;
  logic [memsys_pkg::STRB_W-1:0] w_strb_q;
  logic                          b_valid_q;
  memsys_pkg::axil_resp_e        b_resp_q;
  logic                          ar_fire;
  logic                          aw_fire;
  logic                          w_fire;
  logic                          wr_commit;
  logic                          rd_ok;
  logic                          wr_ok;
  logic [memsys_pkg::ADDR_W-1:0] wr_addr;
  logic [memsys_pkg::DATA_W-1:0] wr_data;
  logic [memsys_pkg::STRB_W-1:0] wr_strb;

  function automatic logic addr_in_range(input logic [memsys_pkg::ADDR_W-1:0] addr);
    return (addr[memsys_pkg::ADDR_W-1:2] < MEM_WORDS);   // word index below depth
  endfunction

  assign o_arready = !r_valid_q;               // one read held at a time
  assign o_awready = !aw_got_q && !b_valid_q;
  assign o_wready  = !w_got_q && !b_valid_q;

  assign ar_fire = i_ar.valid && o_arready;
  assign aw_fire = i_aw.valid && o_awready;
  assign w_fire  = i_w.valid && o_wready;

  // AW and W may land in either order, or together
  assign wr_commit = (aw_got_q || aw_fire) && (w_got_q || w_fire);
  assign wr_addr   = aw_got_q ? aw_addr_q : i_aw.addr;
  assign wr_data   = w_got_q ? w_data_q : i_w.data;
  assign wr_strb   = w_got_q ? w_strb_q : i_w.strb;

  assign rd_ok = addr_in_range(i_ar.addr);
  assign wr_ok = addr_in_range(wr_addr);

  // ----------------------------------------
  // channel control
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      r_valid_q <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_valid_q && i_rready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_commit) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        aw_got_q <= aw_got_q || aw_fire;
        w_got_q  <= w_got_q || w_fire;
      end
      if (wr_commit) begin
        b_valid_q <= 1'b1;
      end else if (i_bready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // payload and memory
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      r_data_q <= rd_ok ? mem[i_ar.addr[IDX_W+1:2]] : '0;
      r_resp_q <= rd_ok ? memsys_pkg::RESP_OKAY : memsys_pkg::RESP_SLVERR;
    end
    if (aw_fire) begin
      aw_addr_q <= i_aw.addr;
    end
    if (w_fire) begin
      w_data_q <= i_w.data;
      w_strb_q <= i_w.strb;
    end
    if (wr_commit) begin
      b_resp_q <= wr_ok ? memsys_pkg::RESP_OKAY : memsys_pkg::RESP_SLVERR;
    end
    if (wr_commit && wr_ok) begin
      for (int b = 0; b < memsys_pkg::STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr[IDX_W+1:2]][8*b +: 8] <= wr_data[8*b +: 8];   // strobed lanes only
        end
      end
    end
  end

  always_comb begin
    o_r.valid = r_valid_q;
    o_r.data  = r_data_q;
    o_r.resp  = r_resp_q;
    o_b.valid = b_valid_q;
    o_b.resp  = b_resp_q;
  end

endmodule

/* verilog/memsys_top.sv */
// memsys_top: request router, AXI4-Lite master bridge and SRAM slave
`timescale 1ns/1ps

module memsys_top #(
  parameter int MEM_WORDS = 256   // slave depth in words
) (
  input  logic                  i_aclk,
  input  logic                  i_reset,
  input  memsys_pkg::fetch_req_t i_fetch_req,
  output logic                  o_fetch_req_ready,
  input  memsys_pkg::data_req_t  i_data_req,
  output logic                  o_data_req_ready,
  output memsys_pkg::mem_rsp_t   o_fetch_rsp,
  output memsys_pkg::mem_rsp_t   o_data_rsp
);

  // ----------------------------------------
  // router to bridge
  logic                          rd_valid;
  logic [memsys_pkg::ADDR_W-1:0] rd_addr;
  logic                          rd_src;
  logic                          rd_ready;
  logic                          wr_valid;
  logic [memsys_pkg::ADDR_W-1:0] wr_addr;
  logic [memsys_pkg::DATA_W-1:0] wr_data;
  logic [memsys_pkg::STRB_W-1:0] wr_strb;
  logic                          wr_ready;
  logic                          rd_done;
  logic [memsys_pkg::DATA_W-1:0] rd_data;
  memsys_pkg::axil_resp_e        rd_resp;
  logic                          rd_done_src;
  logic                          wr_done;
  memsys_pkg::axil_resp_e        wr_resp;

  // bridge to slave
  memsys_pkg::axil_addr_t        aw;
  logic                          awready;
  memsys_pkg::axil_w_t           w;
  logic                          wready;
  memsys_pkg::axil_b_t           b;
  logic                          bready;
  memsys_pkg::axil_addr_t        ar;
  logic                          arready;
  memsys_pkg::axil_r_t           r;
  logic                          rready;

  mem_req_router u_router (
    .i_aclk            (i_aclk),
    .i_reset           (i_reset),
    .i_fetch_req       (i_fetch_req),
    .o_fetch_req_ready (o_fetch_req_ready),
    .i_data_req        (i_data_req),
    .o_data_req_ready  (o_data_req_ready),
    .o_fetch_rsp       (o_fetch_rsp),
    .o_data_rsp        (o_data_rsp),
    .o_rd_valid        (rd_valid),
    .o_rd_addr         (rd_addr),
    .o_rd_src          (rd_src),
    .i_rd_ready        (rd_ready),
    .o_wr_valid        (wr_valid),
    .o_wr_addr         (wr_addr),
    .o_wr_data         (wr_data),
    .o_wr_strb         (wr_strb),
    .i_wr_ready        (wr_ready),
    .i_rd_done         (rd_done),
    .i_rd_data         (rd_data),
    .i_rd_resp         (rd_resp),
    .i_rd_src          (rd_done_src),
    .i_wr_done         (wr_done),
    .i_wr_resp         (wr_resp)
  );

  axil_master_bridge u_bridge (
    .i_aclk     (i_aclk),
    .i_reset    (i_reset),
    .i_rd_valid (rd_valid),
    .i_rd_addr  (rd_addr),
    .i_rd_src   (rd_src),
    .o_rd_ready (rd_ready),
    .i_wr_valid (wr_valid),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_wr_strb  (wr_strb),
    .o_wr_ready (wr_ready),
    .o_rd_done  (rd_done),
    .o_rd_data  (rd_data),
    .o_rd_resp  (rd_resp),
    .o_rd_src   (rd_done_src),
    .o_wr_done  (wr_done),
    .o_wr_resp  (wr_resp),
    .o_aw       (aw),
    .i_awready  (awready),
    .o_w        (w),
    .i_wready   (wready),
    .i_b        (b),
    .o_bready   (bready),
    .o_ar       (ar),
    .i_arready  (arready),
    .i_r        (r),
    .o_rready   (rready)
  );

  axil_sram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_reset   (i_reset),
    .i_aw      (aw),
    .o_awready (awready),
    .i_w       (w),
    .o_wready  (wready),
    .o_b       (b),
    .i_bready  (bready),
    .i_ar      (ar),
    .o_arready (arready),
    .o_r       (r),
    .i_rready  (rready)
  );

endmodule

/* dv/memsys_checker.sv */
// memsys_checker: port assertions backed by a shadow memory of accepted writes
`timescale 1ns/1ps

module memsys_checker #(
  parameter int MEM_WORDS = 256
) (
  input logic                  i_aclk,
  input logic                  i_reset,
  input memsys_pkg::fetch_req_t i_fetch_req,
  input logic                  i_fetch_req_ready,
  input memsys_pkg::data_req_t  i_data_req,
  input logic                  i_data_req_ready,
  input memsys_pkg::mem_rsp_t   i_fetch_rsp,
  input memsys_pkg::mem_rsp_t   i_data_rsp
);

  localparam int   IDX_W     = $clog2(MEM_WORDS);
  localparam logic SRC_FETCH = 1'b0;
  localparam logic SRC_DATA  = 1'b1;

  int unsigned                   fail_count = 0;
  logic [memsys_pkg::DATA_W-1:0] shadow [MEM_WORDS];
  logic                          rst_q = 1'b0;
  logic                          fetch_acc;
  logic                          data_acc;
  logic                          data_wr_acc;
  logic                          data_rd_acc;
  logic                          both_rd;
  logic [memsys_pkg::ADDR_W-1:0] fetch_addr_q;
  logic [memsys_pkg::ADDR_W-1:0] data_addr_q;
  logic                          data_wr_q;
  logic                          fetch_busy_q;
  logic                          data_busy_q;
  logic                          last_src_q;     // source of the last accepted read
  logic                          fetch_in;
  logic                          data_in;
  logic [memsys_pkg::DATA_W-1:0] fetch_exp;
  logic [memsys_pkg::DATA_W-1:0] data_exp;

  function automatic logic in_range(input logic [memsys_pkg::ADDR_W-1:0] addr);
    return (addr >> 2) < 32'(MEM_WORDS);
  endfunction

  function automatic logic [memsys_pkg::DATA_W-1:0] merge_bytes(
    input logic [memsys_pkg::DATA_W-1:0] old_word,
    input logic [memsys_pkg::DATA_W-1:0] new_word,
    input logic [memsys_pkg::STRB_W-1:0] strb
  );
    logic [memsys_pkg::DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < memsys_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign fetch_acc   = i_fetch_req.valid && i_fetch_req_ready;
  assign data_acc    = i_data_req.valid && i_data_req_ready;
  assign data_wr_acc = data_acc && (i_data_req.op == memsys_pkg::MEM_WRITE);
  assign data_rd_acc = data_acc && (i_data_req.op == memsys_pkg::MEM_READ);
  assign both_rd     = i_fetch_req.valid && i_data_req.valid &&
                       (i_data_req.op == memsys_pkg::MEM_READ);
  assign fetch_in    = in_range(fetch_addr_q);
  assign data_in     = in_range(data_addr_q);
  assign fetch_exp   = shadow[fetch_addr_q[IDX_W+1:2]];
  assign data_exp    = shadow[data_addr_q[IDX_W+1:2]];

  // ----------------------------------------
  // request tracking and shadow memory
  always @(posedge i_aclk) begin
    rst_q <= i_reset;
  end

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      fetch_busy_q <= 1'b0;
      data_busy_q  <= 1'b0;
      last_src_q   <= SRC_DATA;   // fetch wins the first tie
    end else begin
      if (fetch_acc) begin
        fetch_addr_q <= i_fetch_req.addr;
        fetch_busy_q <= 1'b1;
        last_src_q   <= SRC_FETCH;
      end else if (i_fetch_rsp.valid) begin
        fetch_busy_q <= 1'b0;
      end
      if (data_acc) begin
        data_addr_q <= i_data_req.addr;
        data_wr_q   <= data_wr_acc;
        data_busy_q <= 1'b1;
      end else if (i_data_rsp.valid) begin
        data_busy_q <= 1'b0;
      end
      if (data_rd_acc) begin
        last_src_q <= SRC_DATA;
      end
      if (data_wr_acc && in_range(i_data_req.addr)) begin
        shadow[i_data_req.addr[IDX_W+1:2]] <= merge_bytes(shadow[i_data_req.addr[IDX_W+1:2]],
                                                          i_data_req.wdata, i_data_req.wstrb);
      end
    end
  end

  // ----------------------------------------
  // assertions
  a_reset_quiet: assert property (@(posedge i_aclk)
    rst_q |-> !(i_fetch_rsp.valid || i_data_rsp.valid || i_fetch_req_ready || i_data_req_ready))
    else begin
      fail_count++;
      $error("response valid or req_ready high during or right after reset");
    end

  a_fetch_one_rsp: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_fetch_rsp.valid |-> fetch_busy_q)
    else begin
      fail_count++;
      $error("fetch response without an outstanding request");
    end

  a_data_one_rsp: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_data_rsp.valid |-> data_busy_q)
    else begin
      fail_count++;
      $error("load/store response without an outstanding request");
    end

  a_fetch_data: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_fetch_rsp.valid && fetch_in |-> !i_fetch_rsp.err && (i_fetch_rsp.rdata == fetch_exp))
    else begin
      fail_count++;
      $error("fetch read of %h gave %h err %b, expected %h",
             fetch_addr_q, i_fetch_rsp.rdata, i_fetch_rsp.err, fetch_exp);
    end

  a_data_data: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_data_rsp.valid && data_in |-> !i_data_rsp.err && (data_wr_q || i_data_rsp.rdata == data_exp))
    else begin
      fail_count++;
      $error("load/store at %h gave %h err %b, expected %h",
             data_addr_q, i_data_rsp.rdata, i_data_rsp.err, data_exp);
    end

  a_fetch_oor: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_fetch_rsp.valid && !fetch_in |-> i_fetch_rsp.err && (i_fetch_rsp.rdata == '0))
    else begin
      fail_count++;
      $error("fetch of out-of-range %h not flagged or data not zero", fetch_addr_q);
    end

  a_data_oor: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_data_rsp.valid && !data_in |-> i_data_rsp.err && (data_wr_q || i_data_rsp.rdata == '0))
    else begin
      fail_count++;
      $error("load/store at out-of-range %h not flagged or data not zero", data_addr_q);
    end

  a_read_fair: assert property (@(posedge i_aclk) disable iff (i_reset)
    both_rd && (fetch_acc || data_rd_acc) |-> ((fetch_acc ? SRC_FETCH : SRC_DATA) != last_src_q))
    else begin
      fail_count++;
      $error("same port granted the read engine twice in a row under contention");
    end

endmodule

/* dv/tb_clock_gen.sv */
// tb_clock_gen: free-running testbench clock and power-on reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2,   // 4 ns period
  parameter int RESET_CYCLES   = 8
) (
  output logic o_aclk,
  output logic o_reset
);

  initial begin
    o_aclk = 1'b0;
    forever #(HALF_PERIOD_NS) o_aclk = ~o_aclk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    o_reset <= 1'b0;                  // released on a rising edge
  end

endmodule

/* dv/memsys_tb.sv */
// stimulus, failure monitor and watchdog for the memory subsystem
`timescale 1ns/1ps

module memsys_tb;

  localparam int MEM_WORDS    = 256;
  localparam int RESET_CYCLES = 8;
  localparam int SEED         = 3;
  localparam int NUM_BOOT     = 2;    // write and fetch held across reset
  localparam int NUM_PAIRS    = 16;   // lone read then a read on both ports at once
  localparam int NUM_CONC     = 8;    // write and fetch in the same cycle
  localparam int NUM_RAND     = 24;   // random strobe write plus two reads
  localparam int NUM_OOR      = 3;
  localparam int NUM_TXNS     = NUM_BOOT + MEM_WORDS + 3 * NUM_PAIRS + 2 * NUM_CONC +
                                3 * NUM_RAND + 5 * NUM_OOR;

  logic                 aclk;
  logic                 reset;
  memsys_pkg::fetch_req_t fetch_req;
  logic                 fetch_req_ready;
  memsys_pkg::data_req_t  data_req;
  logic                 data_req_ready;
  memsys_pkg::mem_rsp_t   fetch_rsp;
  memsys_pkg::mem_rsp_t   data_rsp;

  tb_clock_gen #(
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk (
    .o_aclk  (aclk),
    .o_reset (reset)
  );

  memsys_top #(
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .i_aclk            (aclk),
    .i_reset           (reset),
    .i_fetch_req       (fetch_req),
    .o_fetch_req_ready (fetch_req_ready),
    .i_data_req        (data_req),
    .o_data_req_ready  (data_req_ready),
    .o_fetch_rsp       (fetch_rsp),
    .o_data_rsp        (data_rsp)
  );

  bind memsys_top memsys_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) u_checker (
    .i_aclk            (i_aclk),
    .i_reset           (i_reset),
    .i_fetch_req       (i_fetch_req),
    .i_fetch_req_ready (o_fetch_req_ready),
    .i_data_req        (i_data_req),
    .i_data_req_ready  (o_data_req_ready),
    .i_fetch_rsp       (o_fetch_rsp),
    .i_data_rsp        (o_data_rsp)
  );

  // pattern over the whole byte address
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] addr;
    addr = 32'(idx) << 2;
    return 32'hC0DE_0000 ^ (addr * 32'h9E37_79B9);
  endfunction

  // ----------------------------------------
  // port drivers entered and left just after a rising edge
  task automatic fetch_read(input logic [31:0] addr);
    fetch_req.valid <= 1'b1;
    fetch_req.addr  <= addr;
    do @(negedge aclk); while (!fetch_req_ready);
    @(posedge aclk);                        // handshake edge
    fetch_req.valid <= 1'b0;
    do @(negedge aclk); while (!fetch_rsp.valid);
    @(posedge aclk);
  endtask

  task automatic data_access(input memsys_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
    data_req.valid <= 1'b1;
    data_req.op    <= op;
    data_req.addr  <= addr;
    data_req.wdata <= wdata;
    data_req.wstrb <= wstrb;
    do @(negedge aclk); while (!data_req_ready);
    @(posedge aclk);
    data_req.valid <= 1'b0;
    do @(negedge aclk); while (!data_rsp.valid);
    @(posedge aclk);
  endtask

  // ----------------------------------------
  // failure monitor and watchdog
  always @(negedge aclk) begin
    if (DUT.u_checker.fail_count != 0) begin
      $display("Error at %0t ns: checker assertion failed", $time);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first failed check");
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_TXNS * 40) @(posedge aclk);
    $display("Run timed out after %0d cycles with transactions still open",
             RESET_CYCLES + NUM_TXNS * 40);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------
  // stimulus
  initial begin
    int unsigned idx;
    int unsigned idx_hi;
    logic [31:0] oor_addr [NUM_OOR];
    fetch_req = '0;
    data_req  = '0;
    void'($urandom(SEED));
    oor_addr[0] = 32'(MEM_WORDS) * 4;        // first word past the end
    oor_addr[1] = 32'(MEM_WORDS) * 4 + 32'h40;
    oor_addr[2] = 32'hFFFF_FFFC;
    @(posedge aclk);

    // held valid through reset and accepted once the engines go idle
    fork
      data_access(memsys_pkg::MEM_WRITE, 32'h0, fill_word(0), 4'hF);
      fetch_read(oor_addr[0]);
    join

    for (int i = 0; i < MEM_WORDS; i++) begin
      data_access(memsys_pkg::MEM_WRITE, 32'(i) << 2, fill_word(i), 4'hF);
    end

    // both ports contend for the read engine
    for (int i = 0; i < NUM_PAIRS; i++) begin
      if (i % 2 == 0) begin
        data_access(memsys_pkg::MEM_READ, 32'(i) << 2, '0, '0);   // fetch wins the next tie
      end else begin
        fetch_read(32'(i) << 2);                                  // load/store wins the next tie
      end
      fork
        fetch_read(32'(i) << 2);
        data_access(memsys_pkg::MEM_READ, 32'(MEM_WORDS - 1 - i) << 2, '0, '0);
      join
    end

    // write in the lower half while fetching from the upper half
    for (int i = 0; i < NUM_CONC; i++) begin
      idx    = $urandom % (MEM_WORDS / 2);
      idx_hi = MEM_WORDS / 2 + $urandom % (MEM_WORDS / 2);
      fork
        data_access(memsys_pkg::MEM_WRITE, idx << 2, $urandom, 4'hF);
        fetch_read(idx_hi << 2);
      join
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      idx = $urandom % MEM_WORDS;
      data_access(memsys_pkg::MEM_WRITE, idx << 2, $urandom, 4'($urandom));
      data_access(memsys_pkg::MEM_READ, idx << 2, '0, '0);
      fetch_read(idx << 2);
    end

    for (int i = 0; i < NUM_OOR; i++) begin
      data_access(memsys_pkg::MEM_WRITE, oor_addr[i], $urandom, 4'hF);
      data_access(memsys_pkg::MEM_READ, oor_addr[i], '0, '0);
      fetch_read(oor_addr[i]);
      data_access(memsys_pkg::MEM_READ, 32'h0, '0, '0);   // valid space still intact
      fetch_read(32'(MEM_WORDS - 1) << 2);
    end

    repeat (4) @(posedge aclk);
    if (DUT.u_checker.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "checker reported failures");
    end
  end

endmodule

/* project.f */
common/memsys_pkg.sv
verilog/mem_req_router.sv
axil_master/axil_master_bridge.sv
verilog/axil_sram_slave.sv
verilog/memsys_top.sv
dv/memsys_checker.sv
dv/tb_clock_gen.sv
dv/memsys_tb.sv
